/* verilog/rv32_config.svh */
`ifndef RV32_CONFIG_SVH
`define RV32_CONFIG_SVH

// core boot address, first fetch after rst_n releases
`define RV32_RESET_PC 32'h8000_0000

// architectural register count, x0 included
`define RV32_NUM_REGS 32

`endif

/* verilog/rv32_pkg.sv */
package rv32_pkg;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        op_lui     = 7'b0110111,
        op_auipc   = 7'b0010111,
        op_jal     = 7'b1101111,
        op_jalr    = 7'b1100111,
        op_branch  = 7'b1100011,
        op_load    = 7'b0000011,
        op_store   = 7'b0100011,
        op_alu_imm = 7'b0010011,
        op_alu_reg = 7'b0110011,
        op_system  = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b                  // b straight through
    } alu_op_e;

    typedef enum logic [1:0] {
        src_a_rs1,
        src_a_pc,
        src_a_zero
    } src_a_e;

    typedef enum logic {
        src_b_rs2,
        src_b_imm
    } src_b_e;

    // everything execute and writeback need from one instruction
    typedef struct packed {
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm;           // already sign extended
        alu_op_e     alu_op;
        src_a_e      src_a;
        src_b_e      src_b;
        logic [2:0]  funct3;        // load/store width, branch kind
        logic        reg_write_en;
        logic        mem_read;
        logic        mem_write;
        logic        branch;
        logic        jump;          // jal
        logic        jump_reg;      // jalr
        logic        ebreak;
    } decode_t;

    typedef struct packed {
        logic [31:0] addr;          // byte address, not word aligned
        logic [31:0] wdata;         // lane placed
        logic [3:0]  wmask;
        logic        wen;
        logic        ren;
    } mem_req_t;

endpackage

/* verilog/rv32_ifu.sv */
`include "rv32_config.svh"

module rv32_ifu (
    input  logic        clock,
    input  logic        rst_n,
    input  logic [31:0] next_pc,
    input  logic        ebreak,
    output logic [31:0] pc,
    output logic        halted
);

    logic pc_load;                          // advance this edge

    // freeze on the ebreak itself, so pc stays on the ebreak word
    assign pc_load = !halted && !ebreak;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `RV32_RESET_PC;
        end else if (pc_load) begin
            pc <= next_pc;                  // one cycle from exu to fetch
        end
    end

    // sticky until reset
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            halted <= 1'b0;
        end else if (ebreak) begin
            halted <= 1'b1;
        end
    end

endmodule

/* verilog/rv32_idu.sv */
module rv32_idu (
    input  logic [31:0]       inst,
    output rv32_pkg::decode_t dec
);
    import rv32_pkg::*;

    opcode_e     opcode;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    alu_op_e     alu_fn;                    // funct3/funct7 mapping, shared by both alu forms

    assign opcode = opcode_e'(inst[6:0]);

    // sign extended immediates, all formats
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (inst[14:12])
            3'b000:  alu_fn = (opcode == op_alu_reg && inst[30]) ? alu_sub : alu_add;
            3'b001:  alu_fn = alu_sll;
            3'b010:  alu_fn = alu_slt;
            3'b011:  alu_fn = alu_sltu;
            3'b100:  alu_fn = alu_xor;
            3'b101:  alu_fn = inst[30] ? alu_sra : alu_srl;  // srai shares bit 30
            3'b110:  alu_fn = alu_or;
            default: alu_fn = alu_and;
        endcase
    end

    always_comb begin
        dec        = '0;                    // unknown opcode falls out as a nop
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];
        dec.rd     = inst[11:7];
        dec.funct3 = inst[14:12];
        dec.alu_op = alu_pass_b;            // result unused unless set below
        dec.src_a  = src_a_rs1;
        dec.src_b  = src_b_imm;
        case (opcode)
            op_lui: begin
                dec.imm          = imm_u;
                dec.src_a        = src_a_zero;   // 0 + imm
                dec.alu_op       = alu_add;
                dec.reg_write_en = 1'b1;
            end
            op_auipc: begin
                dec.imm          = imm_u;
                dec.src_a        = src_a_pc;
                dec.alu_op       = alu_add;
                dec.reg_write_en = 1'b1;
            end
            op_jal: begin
                dec.imm          = imm_j;
                dec.src_a        = src_a_pc;
                dec.alu_op       = alu_add;
                dec.jump         = 1'b1;
                dec.reg_write_en = 1'b1;
            end
            op_jalr: begin
                dec.imm          = imm_i;
                dec.alu_op       = alu_add;      // rs1 + imm, bit 0 cleared in exu
                dec.jump_reg     = 1'b1;
                dec.reg_write_en = 1'b1;
            end
            op_branch: begin
                dec.imm    = imm_b;
                dec.src_b  = src_b_rs2;
                dec.branch = 1'b1;
            end
            op_load: begin
                dec.imm          = imm_i;
                dec.alu_op       = alu_add;
                dec.mem_read     = 1'b1;
                dec.reg_write_en = 1'b1;
            end
            op_store: begin
                dec.imm       = imm_s;
                dec.alu_op    = alu_add;         // rs1 + imm
                dec.mem_write = 1'b1;
            end
            op_alu_imm: begin
                dec.imm          = imm_i;
                dec.alu_op       = alu_fn;
                dec.reg_write_en = 1'b1;
            end
            op_alu_reg: begin
                dec.src_b        = src_b_rs2;
                dec.alu_op       = alu_fn;
                dec.reg_write_en = 1'b1;
            end
            op_system: begin
                dec.imm    = imm_i;
                dec.ebreak = (inst == 32'h0010_0073);  // exact ebreak only
            end
            default: ;
        endcase
    end

endmodule

/* verilog/rv32_regfile.sv */
`include "rv32_config.svh"

module rv32_regfile (
    input  logic        clock,
    input  logic        rst_n,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,
    input  logic [4:0]  rd,
    input  logic        wen,
    input  logic [31:0] wdata
);

    // x0 has no storage
    logic [31:0] regs [`RV32_NUM_REGS-1:1];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `RV32_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd != 5'd0) begin    // x0 writes dropped
            regs[rd] <= wdata;
        end
    end

    // async read, same-cycle write is not bypassed
    assign rs1_data = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

/* verilog/rv32_exu.sv */
module rv32_exu (
    input  rv32_pkg::decode_t  dec,
    input  logic [31:0]        pc,
    input  logic [31:0]        rs1_data,
    input  logic [31:0]        rs2_data,
    input  logic               halted,
    output logic [31:0]        alu_result,
    output logic [31:0]        next_pc,
    output rv32_pkg::mem_req_t mem_req
);
    import rv32_pkg::*;

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] pc_plus4;
    logic [31:0] pc_imm;                    // jal and branch target
    logic        br_cond;
    logic        br_taken;
    logic [1:0]  byte_off;

    always_comb begin
        case (dec.src_a)
            src_a_pc:   op_a = pc;
            src_a_zero: op_a = 32'd0;
            default:    op_a = rs1_data;
        endcase
    end

    assign op_b = (dec.src_b == src_b_imm) ? dec.imm : rs2_data;

    always_comb begin
        case (dec.alu_op)
            alu_add:  alu_result = op_a + op_b;
            alu_sub:  alu_result = op_a - op_b;
            alu_sll:  alu_result = op_a << op_b[4:0];
            alu_slt:  alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_result = {31'd0, op_a < op_b};
            alu_xor:  alu_result = op_a ^ op_b;
            alu_srl:  alu_result = op_a >> op_b[4:0];
            alu_sra:  alu_result = $signed(op_a) >>> op_b[4:0];
            alu_or:   alu_result = op_a | op_b;
            alu_and:  alu_result = op_a & op_b;
            default:  alu_result = op_b;    // pass_b
        endcase
    end

    // branch compare on raw register values, not alu operands
    always_comb begin
        case (dec.funct3)
            3'b000:  br_cond = (rs1_data == rs2_data);
            3'b001:  br_cond = (rs1_data != rs2_data);
            3'b100:  br_cond = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  br_cond = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  br_cond = (rs1_data < rs2_data);
            3'b111:  br_cond = (rs1_data >= rs2_data);
            default: br_cond = 1'b0;         // reserved funct3, never taken
        endcase
    end

    assign br_taken = dec.branch & br_cond;
    assign pc_plus4 = pc + 32'd4;
    assign pc_imm   = pc + dec.imm;

    always_comb begin
        if (dec.jump_reg) begin
            next_pc = {alu_result[31:1], 1'b0};
        end else if (dec.jump || br_taken) begin
            next_pc = pc_imm;
        end else begin
            next_pc = pc_plus4;
        end
    end

    assign byte_off = alu_result[1:0];

    always_comb begin
        mem_req.addr  = alu_result;
        mem_req.wdata = rs2_data << {byte_off, 3'b000};   // move data up to its lane
        case (dec.funct3[1:0])
            2'b00:   mem_req.wmask = 4'b0001 << byte_off;
            2'b01:   mem_req.wmask = 4'b0011 << byte_off;
            default: mem_req.wmask = 4'b1111;
        endcase
        if (!dec.mem_write) begin
            mem_req.wmask = 4'b0000;
        end
        mem_req.wen = dec.mem_write & ~halted;
        mem_req.ren = dec.mem_read & ~halted;
    end

endmodule

/* verilog/rv32_wbu.sv */
module rv32_wbu (
    input  rv32_pkg::decode_t dec,
    input  logic [31:0]       pc,
    input  logic [31:0]       alu_result,
    input  logic [31:0]       mem_rdata,
    input  logic              halted,
    output logic [31:0]       wb_data,
    output logic              reg_wen
);

    logic [31:0] lane_data;                 // addressed byte/half moved to bit 0
    logic [31:0] load_data;

    assign lane_data = mem_rdata >> {alu_result[1:0], 3'b000};

    always_comb begin
        case (dec.funct3)
            3'b000:  load_data = {{24{lane_data[7]}}, lane_data[7:0]};     // lb
            3'b001:  load_data = {{16{lane_data[15]}}, lane_data[15:0]};   // lh
            3'b100:  load_data = {24'd0, lane_data[7:0]};                  // lbu
            3'b101:  load_data = {16'd0, lane_data[15:0]};                 // lhu
            default: load_data = mem_rdata;                                // lw
        endcase
    end

    always_comb begin
        if (dec.mem_read) begin
            wb_data = load_data;
        end else if (dec.jump || dec.jump_reg) begin
            wb_data = pc + 32'd4;           // link address
        end else begin
            wb_data = alu_result;
        end
    end

    // nothing retires into the register file once halted
    assign reg_wen = dec.reg_write_en & ~halted;

endmodule

/* verilog/rv32_core.sv */
module rv32_core (
    input  logic               clock,
    input  logic               rst_n,
    output logic [31:0]        pc,
    input  logic [31:0]        inst,
    output rv32_pkg::mem_req_t mem_req,
    input  logic [31:0]        mem_rdata,
    output logic               halted
);
    import rv32_pkg::*;

    decode_t     dec;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] alu_result;
    logic [31:0] next_pc;
    logic [31:0] wb_data;
    logic        reg_wen;               // halted-gated write enable

    rv32_ifu i_ifu (
        .clock   (clock),
        .rst_n   (rst_n),
        .next_pc (next_pc),
        .ebreak  (dec.ebreak),
        .pc      (pc),
        .halted  (halted)
    );

    rv32_idu i_idu (
        .inst (inst),                   // straight from the fetch port
        .dec  (dec)
    );

    rv32_regfile i_regfile (
        .clock    (clock),
        .rst_n    (rst_n),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rd       (dec.rd),
        .wen      (reg_wen),
        .wdata    (wb_data)
    );

    rv32_exu i_exu (
        .dec        (dec),
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .halted     (halted),
        .alu_result (alu_result),
        .next_pc    (next_pc),
        .mem_req    (mem_req)           // out to the data port as is
    );

    rv32_wbu i_wbu (
        .dec        (dec),
        .pc         (pc),
        .alu_result (alu_result),
        .mem_rdata  (mem_rdata),
        .halted     (halted),
        .wb_data    (wb_data),
        .reg_wen    (reg_wen)
    );

endmodule

/* tb/rv32_checker.sv */
module rv32_checker (
    input  logic               clock,
    input  logic               rst_n,
    input  logic [31:0]        pc,
    input  rv32_pkg::mem_req_t mem_req,
    input  logic               halted,
    input  int                 rec,            // record of the instruction now in flight
    input  logic               last_rec,       // ebreak record, the core parks here
    input  logic [31:0]        exp_pc,
    input  logic [31:0]        exp_load,       // word the memory returns, zero without a load
    input  logic [31:0]        exp_store,
    input  logic [31:0]        exp_addr,
    input  logic [31:0]        exp_data,
    input  logic [31:0]        exp_mask,
    output int                 errors
);
    import rv32_pkg::*;

    int          err_count = 0;
    int          ebreak_cycles = 0;            // cycles spent on the ebreak record
    logic [31:0] lane_bits;                    // wmask widened to bit lanes
    logic        halt_exp;
    logic        load_exp;

    assign errors = err_count;

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            err_count++;
            $display("ERROR rec%0d_%s: expected %08h, actual %08h", rec, what, exp, act);
        end
    endtask

    // sample half a cycle after the inputs settle, well before the next edge
    always @(negedge clock) begin
        if (rst_n) begin
            lane_bits = {{8{exp_mask[3]}}, {8{exp_mask[2]}}, {8{exp_mask[1]}}, {8{exp_mask[0]}}};
            halt_exp  = last_rec && (ebreak_cycles > 0);   // high once ebreak has retired
            load_exp  = (exp_load != 32'd0);               // only a load gets a word back
            compare("pc", exp_pc, pc);
            compare("halted", {31'd0, halt_exp}, {31'd0, halted});
            compare("wen", {31'd0, exp_store[0]}, {31'd0, mem_req.wen});   // also after halt
            compare("ren", {31'd0, load_exp}, {31'd0, mem_req.ren});
            compare("wmask", exp_mask, {28'd0, mem_req.wmask});            // zero without a store
            if (exp_store[0]) begin
                compare("addr", exp_addr, mem_req.addr);
                // bytes outside the mask are don't care
                compare("wdata", exp_data & lane_bits, mem_req.wdata & lane_bits);
            end
            if (last_rec) begin
                ebreak_cycles++;
            end
        end
    end

endmodule

/* tb/rv32_tb.sv */
module rv32_tb;
    import rv32_pkg::*;

    localparam int MAX_REC = 64;
    localparam int REC_W   = 7;                // pc, inst, load word, store, addr, data, mask

    logic        clock;
    logic        rst_n;
    logic [31:0] pc;
    logic [31:0] inst;
    mem_req_t    mem_req;
    logic [31:0] mem_rdata;
    logic        halted;

    logic [31:0] gold [0:MAX_REC*REC_W-1];
    int          num_rec;
    int          idx;                          // record index of the instruction at pc
    int          cycles;
    int          limit;
    int          check_errs;
    int          fetch_errs;
    int          timeout_errs;

    rv32_core i_dut (
        .clock     (clock),
        .rst_n     (rst_n),
        .pc        (pc),
        .inst      (inst),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .halted    (halted)
    );

    rv32_checker i_checker (
        .clock     (clock),
        .rst_n     (rst_n),
        .pc        (pc),
        .mem_req   (mem_req),
        .halted    (halted),
        .rec       (idx),
        .last_rec  (idx == num_rec - 1),
        .exp_pc    (gold[idx*REC_W]),
        .exp_load  (gold[idx*REC_W+2]),
        .exp_store (gold[idx*REC_W+3]),
        .exp_addr  (gold[idx*REC_W+4]),
        .exp_data  (gold[idx*REC_W+5]),
        .exp_mask  (gold[idx*REC_W+6]),
        .errors    (check_errs)
    );

    always #10 clock = ~clock;

    // instruction by pc lookup, load data by retire order
    task automatic drive_inputs();
        bit hit;
        hit = 1'b0;
        for (int n = 0; n < num_rec; n++) begin
            if (!hit && gold[n*REC_W] == pc) begin
                inst = gold[n*REC_W+1];
                hit  = 1'b1;
            end
        end
        if (!hit) begin
            fetch_errs++;
            $display("fetch at pc %08h is outside the program", pc);
            inst = 32'h0000_0013;              // nop
        end
        mem_rdata = gold[idx*REC_W+2];
    endtask

    initial begin
        clock        = 1'b0;
        rst_n        = 1'b0;
        inst         = 32'h0000_0013;
        mem_rdata    = 32'd0;
        idx          = 0;
        num_rec      = 0;
        cycles       = 0;
        fetch_errs   = 0;
        timeout_errs = 0;
        for (int n = 0; n < MAX_REC*REC_W; n++) begin
            gold[n] = 32'd0;
        end
        $readmemh("tb/rv32_golden.hex", gold);
        while (num_rec < MAX_REC && gold[num_rec*REC_W] != 32'd0) begin
            num_rec++;                         // no record sits at pc 0
        end
        limit = num_rec + 20;
        repeat (5) @(posedge clock);
        #2 rst_n = 1'b1;
        drive_inputs();                        // pc sits on the reset vector by now
        while (!halted && cycles < limit) begin
            @(posedge clock);
            cycles++;
            if (idx < num_rec - 1) begin
                idx++;                         // parks on the ebreak record
            end
            #2 drive_inputs();
        end
        if (!halted) begin
            timeout_errs++;
            $display("timeout: halted never went high within %0d cycles", limit);
        end
        repeat (3) begin
            @(posedge clock);                  // pc and data port must stay frozen
            #2 drive_inputs();
        end
        @(negedge clock);
        #1;
        $display("errors: check %0d, fetch %0d, timeout %0d",
                 check_errs, fetch_errs, timeout_errs);
        if (check_errs + fetch_errs + timeout_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* tb/rv32_golden.hex */
// columns: pc inst load_word store_flag store_addr store_data store_mask
// one record per retired instruction, store fields zero when nothing is stored
80000000 800010b7 00000000 0 00000000 00000000 0
80000004 00012117 00000000 0 00000000 00000000 0
80000008 0020a023 00000000 1 80001000 80012004 f
8000000c ffb00193 00000000 0 00000000 00000000 0
80000010 ffc1a213 00000000 0 00000000 00000000 0
80000014 0051b293 00000000 0 00000000 00000000 0
80000018 00421313 00000000 0 00000000 00000000 0
8000001c 005363b3 00000000 0 00000000 00000000 0
80000020 0070a223 00000000 1 80001004 00000010 f
80000024 0f01c413 00000000 0 00000000 00000000 0
80000028 7ff47493 00000000 0 00000000 00000000 0
8000002c 40445513 00000000 0 00000000 00000000 0
80000030 01c45593 00000000 0 00000000 00000000 0
80000034 40b48633 00000000 0 00000000 00000000 0
80000038 00a606b3 00000000 0 00000000 00000000 0
8000003c 40b15733 00000000 0 00000000 00000000 0
80000040 00118013 00000000 0 00000000 00000000 0
80000044 00e6c7b3 00000000 0 00000000 00000000 0
80000048 000787b3 00000000 0 00000000 00000000 0
8000004c 00f0a423 00000000 1 80001008 ffff06ee f
80000050 00520463 00000000 0 00000000 00000000 0
80000054 00028463 00000000 0 00000000 00000000 0
8000005c 00029463 00000000 0 00000000 00000000 0
80000060 00521463 00000000 0 00000000 00000000 0
80000068 00324463 00000000 0 00000000 00000000 0
8000006c 0041c463 00000000 0 00000000 00000000 0
80000074 0041d463 00000000 0 00000000 00000000 0
80000078 00325463 00000000 0 00000000 00000000 0
80000080 0041e463 00000000 0 00000000 00000000 0
80000084 00326463 00000000 0 00000000 00000000 0
8000008c 00327463 00000000 0 00000000 00000000 0
80000090 0041f463 00000000 0 00000000 00000000 0
80000098 00c0086f 00000000 0 00000000 00000000 0
800000a4 01d808e7 00000000 0 00000000 00000000 0
800000b8 0100a623 00000000 1 8000100c 8000009c f
800000bc 0110a823 00000000 1 80001010 800000a8 f
800000c0 00108903 93fe7f81 0 00000000 00000000 0
800000c4 00308983 93fe7f81 0 00000000 00000000 0
800000c8 0000ca03 93fe7f81 0 00000000 00000000 0
800000cc 0020ca83 93fe7f81 0 00000000 00000000 0
800000d0 00009b03 93fe7f81 0 00000000 00000000 0
800000d4 00209b83 93fe7f81 0 00000000 00000000 0
800000d8 0020dc03 93fe7f81 0 00000000 00000000 0
800000dc 0000ac83 93fe7f81 0 00000000 00000000 0
800000e0 0120aa23 00000000 1 80001014 0000007f f
800000e4 0130ac23 00000000 1 80001018 ffffff93 f
800000e8 0140ae23 00000000 1 8000101c 00000081 f
800000ec 0350a023 00000000 1 80001020 000000fe f
800000f0 0360a223 00000000 1 80001024 00007f81 f
800000f4 0370a423 00000000 1 80001028 ffff93fe f
800000f8 0380a623 00000000 1 8000102c 000093fe f
800000fc 0390a823 00000000 1 80001030 93fe7f81 f
80000100 03908a23 00000000 1 80001034 00000081 1
80000104 03908aa3 00000000 1 80001035 00008100 2
80000108 03908b23 00000000 1 80001036 00810000 4
8000010c 03908ba3 00000000 1 80001037 81000000 8
80000110 03909c23 00000000 1 80001038 00007f81 3
80000114 03909d23 00000000 1 8000103a 7f810000 c
80000118 00100073 00000000 0 00000000 00000000 0

/* sources.f */
+incdir+verilog
verilog/rv32_pkg.sv
verilog/rv32_ifu.sv
verilog/rv32_idu.sv
verilog/rv32_regfile.sv
verilog/rv32_exu.sv
verilog/rv32_wbu.sv
verilog/rv32_core.sv
tb/rv32_checker.sv
tb/rv32_tb.sv

/* run.sh */
#!/bin/sh
# build and run the rv32 testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module rv32_tb -o rv32_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/rv32_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -qx "all tests passed" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL, see sim.log"
    exit 1
fi
